//--- common/pce_glue_pkg.sv
// Shared types and constants for the PC Engine console glue logic
package pce_glue_pkg;

	// ====================
	// Host download port
	// ====================

	// One host download cycle as seen by the glue logic
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
	} dl_port_t;

	// User options taken from the menu
	typedef struct packed {
		logic byte_swap;
		logic multitap_en;
		logic six_button_en;
	} pce_options_t;

	// Host pad word
	// Bits 3:0 are up, down, left, right and the buttons sit above them
	typedef logic [11:0] pad_word_t;

	// ====================
	// Cheat record
	// ====================

	// Field view of the record, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Same 128 bits seen as eight 16-bit host slots or as fields
	// Slot 0 is the bottom word of replace, slot 7 the top word of flags
	typedef union packed {
		logic [7:0][15:0] slot;
		cheat_fields_t    field;
	} cheat_code_u;

	// Cheat output towards the console core
	typedef struct packed {
		logic        valid;
		cheat_code_u code;
	} cheat_out_t;

	// ====================
	// Download constants
	// ====================

	// All index bits set marks a cheat download
	localparam logic [7:0] CODE_INDEX = 8'd255;

	// Low five index bits of a SuperGrafx image
	localparam logic [4:0] SGX_INDEX = 5'd2;

	// ROM header regions, with and without the 512-byte copier header
	localparam logic [23:0] HDR_BLOCK_A = 24'h002120;
	localparam logic [23:0] HDR_BLOCK_B = 24'h001F20;

	// Populous signature words at offsets 6, 8, 10 and 12 of a region
	// Entry 0 belongs to offset 6
	localparam logic [3:0][15:0] POP_SIG = {16'h5355, 16'h4F4C, 16'h5550, 16'h4F50};

endpackage

//--- loader/cart_loader.sv
// Cartridge loader that streams host download words into both ROM memories
module cart_loader #(
	parameter int ROM_ADDR_W = 24
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_glue_pkg::dl_port_t     dl,
	input  logic                       cart_dl,
	input  pce_glue_pkg::pce_options_t opts,
	input  logic                       sd_wrack,
	input  logic                       dd_wrack,
	output logic                       rom_wr,
	output logic [ROM_ADDR_W-1:0]      romwr_a,
	output logic [15:0]                romwr_d,
	output logic                       ioctl_wait,
	output logic                       wr_accept,
	output logic                       dl_start,
	output logic [7:0]                 rom_sz
);

	logic        dl_d;
	logic        wr_toggle = 1'b0;
	logic        both_acked;
	logic [15:0] swapped;

	// ====================
	// Data path
	// ====================

	// Mirror the bit order inside each byte for swapped dumps
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			swapped[i]     = dl.data[7 - i];
			swapped[8 + i] = dl.data[15 - i];
		end
	end

	// Host holds the word stable while the loader waits
	assign romwr_d = opts.byte_swap ? swapped : dl.data;

	// ====================
	// Write sequencing
	// ====================

	always_ff @(posedge clk_sys) begin
		dl_d <= cart_dl;
	end

	assign dl_start = cart_dl & ~dl_d;

	// The start cycle only rewinds the address
	assign wr_accept = dl.wr & cart_dl & ~dl_start;

	// Each memory copies the toggle back once its write is done
	assign both_acked = (sd_wrack == wr_toggle) && (dd_wrack == wr_toggle);

	// Toggle request towards both memories, released by the matching acknowledges
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait <= 1'b0;
		end else if (dl_start) begin
			romwr_a <= '0;
		end else if (wr_accept) begin
			ioctl_wait <= 1'b1;
			wr_toggle  <= ~wr_toggle;
		end else if (ioctl_wait && both_acked) begin
			ioctl_wait <= 1'b0;
			romwr_a    <= romwr_a + ROM_ADDR_W'(2);
		end
	end

	assign rom_wr = wr_toggle;

	// Final address after a download gives the ROM size in 64 KiB units
	assign rom_sz = romwr_a[23:16];

	// ====================
	// Checks
	// ====================

	// Host must hold off while both memories are still busy
	assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wait |-> !(dl.wr && cart_dl))
		else $error("cart_loader: download write while waiting for acknowledge");

	// Host writes whole words at even byte addresses
	assert property (@(posedge clk_sys) disable iff (reset)
		(dl.wr && cart_dl) |-> !dl.addr[0])
		else $error("cart_loader: odd host download address");

endmodule

//--- loader/cart_header_scan.sv
// ROM header scan that flags Populous images and latches the SuperGrafx type
module cart_header_scan (
	input  logic        clk_sys,
	input  logic        dl_start,
	input  logic        wr_accept,
	input  logic [7:0]  index,
	input  logic [23:0] addr,
	input  logic [15:0] data,
	output logic [1:0]  populous,
	output logic        sgx
);

	import pce_glue_pkg::*;

	logic       in_header;
	logic       sig_word;
	logic [2:0] sig_pos;
	logic [1:0] sig_idx;

	// Either 16-byte region, with or without the copier header
	assign in_header = (addr[23:4] == HDR_BLOCK_A[23:4]) ||
	                   (addr[23:4] == HDR_BLOCK_B[23:4]);

	// Signature words live at offsets 6 to 12 of the region
	assign sig_word = !addr[0] && (addr[3:1] >= 3'd3) && (addr[3:1] <= 3'd6);
	assign sig_pos  = addr[3:1] - 3'd3;
	assign sig_idx  = sig_pos[1:0];

	// ====================
	// Detection
	// ====================

	// Both candidates start valid, a single wrong word rules one out
	// Address bit 13 tells region A (bit 1) from region B (bit 0)
	always_ff @(posedge clk_sys) begin
		if (dl_start) begin
			populous <= 2'b11;
			sgx      <= (index[4:0] == SGX_INDEX);
		end else if (wr_accept && in_header && sig_word) begin
			if (data != POP_SIG[sig_idx]) begin
				populous[addr[13]] <= 1'b0;
			end
		end
	end

endmodule

//--- logic/cheat_code_assembler.sv
// Cheat code assembler that packs eight host words into one cheat record
module cheat_code_assembler (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     wr,
	input  logic [3:0]               offset,
	input  logic [15:0]              data,
	output pce_glue_pkg::cheat_out_t code
);

	import pce_glue_pkg::*;

	logic        valid_q;
	cheat_code_u record_q;
	logic [2:0]  slot_idx;

	// Field n sits at offset 4n, flags first and replace last
	// Slots count from the bottom of the record, so the field order flips
	// Offset bit 1 picks the top word of the field
	assign slot_idx = {~offset[3:2], offset[1]};

	// ====================
	// Record capture
	// ====================

	always_ff @(posedge clk_sys) begin
		if (wr) begin
			record_q.slot[slot_idx] <= data;
		end
	end

	// Last word of the record clocks it into the core
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= wr && (offset == 4'd14);
		end
	end

	assign code.valid = valid_q;
	assign code.code  = record_q;

	// ====================
	// Checks
	// ====================

	// Core takes one record per strobe
	assert property (@(posedge clk_sys) disable iff (reset)
		code.valid |=> !code.valid)
		else $error("cheat_code_assembler: valid held for two cycles");

endmodule

//--- logic/joypad_mux.sv
// Joypad multiplexer that serves host pad words to the console as 4-bit nibbles
module joypad_mux #(
	parameter int NUM_PADS = 5
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_glue_pkg::pad_word_t    pads [NUM_PADS],
	input  pce_glue_pkg::pce_options_t opts,
	input  logic                       sel,
	input  logic                       clr,
	output logic [3:0]                 nibble
);

	import pce_glue_pkg::*;

	// One spare code above the last pad reads as idle
	localparam int PORT_W = $clog2(NUM_PADS + 1);

	logic [PORT_W-1:0] port;
	logic              high_buttons;
	logic              sel_d;
	logic              clr_d;
	pad_word_t         cur_pad;
	logic [11:0]       con_word;
	logic [3:0]        nib_next;

	// ====================
	// Pad selection
	// ====================

	// Ports past the last pad read as a pad with nothing pressed
	always_comb begin
		if (port < PORT_W'(NUM_PADS)) begin
			cur_pad = pads[port];
		end else begin
			cur_pad = '0;
		end
	end

	// Console order is up, right, down, left, then buttons, all active low
	assign con_word = ~{cur_pad[11:4], cur_pad[1], cur_pad[2], cur_pad[0], cur_pad[3]};

	// Six-button pads answer with the extra buttons on every other scan
	always_comb begin
		case ({high_buttons, sel})
			2'b00:   nib_next = con_word[7:4];
			2'b01:   nib_next = con_word[3:0];
			2'b10:   nib_next = con_word[11:8];
			default: nib_next = 4'b0000;
		endcase
	end

	// ====================
	// Scan sequencing
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port         <= '0;
			high_buttons <= 1'b0;
			sel_d        <= 1'b0;
			clr_d        <= 1'b0;
			nibble       <= 4'd0;
		end else begin
			sel_d <= sel;
			clr_d <= clr;
			if (clr) begin
				// Clear restarts the multitap at the first port
				port   <= '0;
				nibble <= 4'd0;
				if (!clr_d) begin
					high_buttons <= ~high_buttons & opts.six_button_en;
				end
			end else begin
				nibble <= nib_next;
				if (sel && !sel_d && opts.multitap_en) begin
					port <= port + 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/pce_glue_top.sv
// Console glue top that routes host downloads and pads to the loader, cheats and joypad
module pce_glue_top #(
	parameter int ROM_ADDR_W = 24,
	parameter int NUM_PADS   = 5
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_glue_pkg::dl_port_t     dl,
	input  pce_glue_pkg::pce_options_t opts,
	input  pce_glue_pkg::pad_word_t    pads [NUM_PADS],
	input  logic                       sd_wrack,
	input  logic                       dd_wrack,
	input  logic                       sel,
	input  logic                       clr,
	output logic                       rom_wr,
	output logic [ROM_ADDR_W-1:0]      romwr_a,
	output logic [15:0]                romwr_d,
	output logic                       ioctl_wait,
	output logic [7:0]                 rom_sz,
	output logic                       rom_pop,
	output logic                       sgx,
	output pce_glue_pkg::cheat_out_t   cheat,
	output logic                       cheat_reset,
	output logic [3:0]                 pad_nibble
);

	import pce_glue_pkg::*;

	logic       code_index;
	logic       code_wr;
	logic       cart_dl;
	logic       wr_accept;
	logic       dl_start;
	logic [1:0] populous;

	// Index 255 carries cheat records, anything else is a cartridge
	assign code_index = (dl.index == CODE_INDEX);
	assign code_wr    = dl.download & code_index & dl.wr;
	assign cart_dl    = dl.download & ~code_index;

	// First word of any download flushes the cheat list
	assign cheat_reset = dl.download && dl.wr && (dl.addr == '0);

	cart_loader #(
		.ROM_ADDR_W (ROM_ADDR_W)
	) u_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.cart_dl    (cart_dl),
		.opts       (opts),
		.sd_wrack   (sd_wrack),
		.dd_wrack   (dd_wrack),
		.rom_wr     (rom_wr),
		.romwr_a    (romwr_a),
		.romwr_d    (romwr_d),
		.ioctl_wait (ioctl_wait),
		.wr_accept  (wr_accept),
		.dl_start   (dl_start),
		.rom_sz     (rom_sz)
	);

	cart_header_scan u_header_scan (
		.clk_sys   (clk_sys),
		.dl_start  (dl_start),
		.wr_accept (wr_accept),
		.index     (dl.index),
		.addr      (romwr_a[23:0]),
		.data      (romwr_d),
		.populous  (populous),
		.sgx       (sgx)
	);

	// Image size bit 9 is set when a copier header precedes the ROM
	assign rom_pop = populous[romwr_a[9]];

	cheat_code_assembler u_cheat (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr      (code_wr),
		.offset  (dl.addr[3:0]),
		.data    (dl.data),
		.code    (cheat)
	);

	joypad_mux #(
		.NUM_PADS (NUM_PADS)
	) u_joypad (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pads    (pads),
		.opts    (opts),
		.sel     (sel),
		.clr     (clr),
		.nibble  (pad_nibble)
	);

endmodule

//--- tb/tb_vectors.svh
// Stimulus and expected-value table for the console glue testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: op, a, b, c, exp
//   pad    a = pad 0 word, b = {clr, sel}, exp = nibble
//   mtap   no operands, expected nibbles come from the port number
//   six    a = pad 0 word, exp = {nibble after first clr, nibble after second clr}
//   load   a = word count, b = first data word, c[0] = byte swap, exp = rom_sz
//   hdr    a = byte address of a corrupted word or 0, c = index, exp = {rom_pop, sgx}
//   cheat  a = first word, each following word adds 16'h1111
typedef struct packed {
	logic [3:0]  op;
	logic [15:0] a;
	logic [15:0] b;
	logic [7:0]  c;
	logic [15:0] exp;
} vec_t;

localparam logic [3:0] OP_PAD   = 4'd0;
localparam logic [3:0] OP_MTAP  = 4'd1;
localparam logic [3:0] OP_SIX   = 4'd2;
localparam logic [3:0] OP_LOAD  = 4'd3;
localparam logic [3:0] OP_HDR   = 4'd4;
localparam logic [3:0] OP_CHEAT = 4'd5;

localparam int NUM_VECS = 10;

localparam vec_t VECTORS [NUM_VECS] = '{
	'{OP_PAD,   16'h0951, 16'h0001, 8'h00, 16'h000D},
	'{OP_PAD,   16'h0951, 16'h0000, 8'h00, 16'h000A},
	'{OP_PAD,   16'h0951, 16'h0002, 8'h00, 16'h0000},
	'{OP_MTAP,  16'h0000, 16'h0000, 8'h00, 16'h0000},
	'{OP_SIX,   16'h0951, 16'h0000, 8'h00, 16'h006A},
	'{OP_LOAD,  16'h0006, 16'h1E2D, 8'h00, 16'h0000},
	'{OP_LOAD,  16'h8000, 16'h80F1, 8'h01, 16'h0001},
	'{OP_HDR,   16'h0000, 16'h0000, 8'h02, 16'h0003},
	'{OP_HDR,   16'h212A, 16'h0000, 8'h01, 16'h0000},
	'{OP_CHEAT, 16'h1357, 16'h0000, 8'h00, 16'h0000}
};

`endif

//--- tb/tb_pce_glue.sv
// Testbench for the console glue top with a ROM acknowledge model and a table-driven check loop
module tb_pce_glue;

	import pce_glue_pkg::*;

	`include "tb_vectors.svh"

	logic         clk_sys = 1'b0;
	logic         reset;
	dl_port_t     dl;
	pce_options_t opts;
	pad_word_t    pads [5];
	logic         sd_wrack = 1'b0;
	logic         dd_wrack = 1'b0;
	logic         sel, clr;
	logic         rom_wr, ioctl_wait, rom_pop, sgx, cheat_reset;
	logic [23:0]  romwr_a;
	logic [15:0]  romwr_d;
	logic [7:0]   rom_sz;
	logic [3:0]   pad_nibble;
	cheat_out_t   cheat;
	integer       seed = 46;
	int           errors = 0;
	int           failed_tests = 0;
	int           sd_cnt = 0;
	int           dd_cnt = 0;

	always #50 clk_sys = ~clk_sys;

	pce_glue_top #(.ROM_ADDR_W(24), .NUM_PADS(5)) dut_i (.*);

	// ====================
	// ROM acknowledge model
	// ====================

	// Each memory copies the toggle back after 0 to 3 cycles
	always @(posedge clk_sys) begin
		if (sd_wrack == rom_wr) sd_cnt <= $unsigned($random(seed)) % 4;
		else if (sd_cnt == 0) sd_wrack <= rom_wr;
		else sd_cnt <= sd_cnt - 1;
	end

	always @(posedge clk_sys) begin
		if (dd_wrack == rom_wr) dd_cnt <= $unsigned($random(seed)) % 4;
		else if (dd_cnt == 0) dd_wrack <= rom_wr;
		else dd_cnt <= dd_cnt - 1;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Bit order mirrored inside each byte
	function automatic logic [15:0] swap_bits(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) r[i] = w[(i / 8) * 8 + 7 - (i % 8)];
		return r;
	endfunction

	// Image word with the signature in the copier-header region
	function automatic logic [15:0] header_word(input logic [24:0] addr, input logic [15:0] bad);
		logic [15:0] w;
		w = addr[15:0] ^ 16'hC3A5;
		if (addr >= 25'h2126 && addr <= 25'h212C) w = POP_SIG[(addr - 25'h2126) / 2];
		if (bad != 16'h0 && addr == 25'(bad)) w = ~w;
		return w;
	endfunction

	task automatic drive_pad(input logic c, input logic s);
		@(posedge clk_sys);
		clr <= c;
		sel <= s;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= index;
		dl.wr       <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		dl.download <= 1'b0;
		@(posedge clk_sys);
	endtask

	// One host write, then wait for both memories with a timeout
	task automatic write_word(input logic [24:0] addr, input logic [15:0] data,
	                          input logic [15:0] exp_d, input bit check);
		logic prev_wr;
		int   n;
		prev_wr = rom_wr;
		@(posedge clk_sys);
		dl.wr   <= 1'b1;
		dl.addr <= addr;
		dl.data <= data;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);
		if (check) begin
			check_value("rom_wr", 32'(rom_wr), 32'(!prev_wr));
			check_value("ioctl_wait", 32'(ioctl_wait), 1);
			check_value("romwr_d", 32'(romwr_d), 32'(exp_d));
			check_value("romwr_a", 32'(romwr_a), 32'(addr));
		end
		n = 0;
		while (ioctl_wait && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (ioctl_wait) begin
			$display("Timeout: ioctl_wait still high 20 cycles after the write at %h", addr);
			errors++;
		end else if (check) begin
			check_value("romwr_a", 32'(romwr_a), 32'(addr + 2));
		end
	endtask

	task automatic run_cheat(input logic [15:0] base);
		logic [15:0] w [8];
		int          pulses;
		pulses = 0;
		start_download(CODE_INDEX);
		for (int k = 0; k < 8; k++) begin
			w[k] = base + 16'(k * 16'h1111);
			@(posedge clk_sys);
			dl.wr   <= 1'b1;
			dl.addr <= 25'(2 * k);
			dl.data <= w[k];
			@(negedge clk_sys);
			check_value("cheat_reset", 32'(cheat_reset), 32'(k == 0));
			@(posedge clk_sys);
			dl.wr <= 1'b0;
			@(negedge clk_sys);
			if (cheat.valid) pulses++;
		end
		for (int n = 0; n < 3; n++) begin
			@(negedge clk_sys);
			if (cheat.valid) pulses++;
		end
		check_value("cheat.valid pulses", pulses, 1);
		check_value("cheat.flags", cheat.code.field.flags, {w[1], w[0]});
		check_value("cheat.address", cheat.code.field.address, {w[3], w[2]});
		check_value("cheat.compare", cheat.code.field.compare, {w[5], w[4]});
		check_value("cheat.replace", cheat.code.field.replace, {w[7], w[6]});
		end_download();
	endtask

	// ====================
	// Check loop
	// ====================

	initial begin
		int errs_before;
		logic [15:0] d;
		reset = 1'b1;
		dl = '0;
		opts = '0;
		sel = 1'b0;
		clr = 1'b0;
		for (int i = 0; i < 5; i++) pads[i] = '0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		for (int t = 0; t < NUM_VECS; t++) begin
			errs_before = errors;
			// Every test starts on a rising edge with all options off
			@(posedge clk_sys);
			opts <= '0;
			case (VECTORS[t].op)
				OP_PAD: begin
					pads[0] <= VECTORS[t].a[11:0];
					drive_pad(VECTORS[t].b[1], VECTORS[t].b[0]);
					check_value("pad_nibble", 32'(pad_nibble), 32'(VECTORS[t].exp[3:0]));
				end
				OP_MTAP: begin
					opts.multitap_en <= 1'b1;
					for (int k = 0; k < 5; k++) pads[k] <= {4'h0, 4'(k + 1), 4'h0};
					drive_pad(1'b1, 1'b0);
					for (int k = 0; k < 6; k++) begin
						if (k > 0) drive_pad(1'b0, 1'b1);
						drive_pad(1'b0, 1'b0);
						check_value("pad_nibble", 32'(pad_nibble),
						            32'((k < 5) ? 4'(~(k + 1)) : 4'hF));
					end
				end
				OP_SIX: begin
					opts.six_button_en <= 1'b1;
					pads[0] <= VECTORS[t].a[11:0];
					drive_pad(1'b0, 1'b0);
					drive_pad(1'b1, 1'b0);
					drive_pad(1'b0, 1'b0);
					check_value("pad_nibble", 32'(pad_nibble), 32'(VECTORS[t].exp[7:4]));
					drive_pad(1'b1, 1'b0);
					drive_pad(1'b0, 1'b0);
					check_value("pad_nibble", 32'(pad_nibble), 32'(VECTORS[t].exp[3:0]));
				end
				OP_LOAD: begin
					opts.byte_swap <= VECTORS[t].c[0];
					start_download(8'h01);
					for (int k = 0; k < int'(VECTORS[t].a); k++) begin
						d = VECTORS[t].b + 16'(k * 16'h0137);
						write_word(25'(2 * k), d, VECTORS[t].c[0] ? swap_bits(d) : d, 1'b1);
					end
					check_value("rom_sz", 32'(rom_sz), 32'(VECTORS[t].exp[7:0]));
					end_download();
				end
				OP_HDR: begin
					start_download(VECTORS[t].c);
					for (int k = 0; k < 16'h1100; k++) begin
						d = header_word(25'(2 * k), VECTORS[t].a);
						write_word(25'(2 * k), d, d, 1'b0);
					end
					check_value("rom_pop", 32'(rom_pop), 32'(VECTORS[t].exp[1]));
					check_value("sgx", 32'(sgx), 32'(VECTORS[t].exp[0]));
					end_download();
				end
				default: run_cheat(VECTORS[t].a);
			endcase
			if (errors == errs_before) begin
				$display("Test %0d (op %0d): ok", t, VECTORS[t].op);
			end else begin
				$display("Test %0d (op %0d): failed", t, VECTORS[t].op);
				failed_tests++;
			end
		end
		$display("Tests run %0d, failed %0d, errors %0d", NUM_VECS, failed_tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+tb
common/pce_glue_pkg.sv
loader/cart_loader.sv
loader/cart_header_scan.sv
logic/cheat_code_assembler.sv
logic/joypad_mux.sv
logic/pce_glue_top.sv
tb/tb_pce_glue.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_pce_glue
FLIST     = project.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
